/* scrollSubsystem.f */
scrollPkg.sv
scrollCtrl.sv
flashToNametable.sv
spiFlashReader.sv
nameTableRam.sv
scrollSubsystem.sv
spiFlashModel.sv
scrollSubsystemTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= scrollSubsystemTb
FILELIST  ?= scrollSubsystem.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* scrollSubsystemTb.sv */
`timescale 1ns/100ps

module scrollSubsystemTb;

    typedef struct packed {
        logic [7:0]  cntMax;
        logic [7:0]  bgMax;
        logic [23:0] start;
        logic [15:0] frames;
        logic [7:0]  expPtr;   // mapScrollPtr after the last frame
        logic [7:0]  expCnt;
    } stimRow_t;

    logic        clk = 1'b0;
    logic        rstN;
    logic        scrollEn;
    logic [7:0]  scrollCntMax;
    logic [23:0] flashAddrStart;
    logic [7:0]  mapBackgroundMax;
    logic        vgaIntr;
    logic [8:0]  ramReadAddr;
    logic [7:0]  mapBackgroundCnt;
    logic [7:0]  mapScrollPtr;
    logic [8:0]  scrollPtrOut;
    logic        scrollingFlag;
    logic        fetchBusy;
    logic [31:0] ramReadData;
    logic        spiClk;
    logic        spiCsN;
    logic        spiMosi;
    logic        spiMiso;

    stimRow_t    stimTable [4];
    int          errors   = 0;
    int          timeouts = 0;

    logic [8:0]  modelPtr;   // reference pointer, counter and divider
    logic [8:0]  modelPrev;
    logic [7:0]  modelCnt;
    logic [7:0]  modelDiv;

    scrollSubsystem dut_i (.*);
    spiFlashModel flash_i (.*);

    always #5 clk = ~clk;

    function automatic logic [7:0] expectedByte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
    endfunction

    // lane 0 holds the lowest flash address
    function automatic logic [31:0] expectedWord(input logic [23:0] a);
        return {expectedByte(a + 24'd3), expectedByte(a + 24'd2),
                expectedByte(a + 24'd1), expectedByte(a)};
    endfunction

    function automatic logic [23:0] imageBase();
        return flashAddrStart + 24'(modelCnt) * 24'(scrollPkg::MapStride);
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        errors++;
        $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic waitForBusy(input logic level, input int limit);
        int n;
        n = 0;
        while (fetchBusy !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (fetchBusy !== level) begin
            timeouts++;
            $display("timeout: fetchBusy did not go to %0b within %0d cycles", level, limit);
        end
    endtask

    task automatic readRamWord(input logic [8:0] addr, output logic [31:0] data);
        @(posedge clk);
        ramReadAddr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = ramReadData;
    endtask

    task automatic checkRow(input logic [23:0] flashAddr, input logic [8:0] ramAddr,
                            input int nBytes);
        logic [31:0] got;
        logic [31:0] exp;
        int          w;
        for (w = 0; w < nBytes / 4; w++) begin
            readRamWord(ramAddr + 9'(w), got);
            exp = expectedWord(flashAddr + 24'(4 * w));
            assert (got == exp)
                else reportMismatch($sformatf("RAM word %0d", ramAddr + 9'(w)), got, exp);
        end
    endtask

    task automatic checkIdle();
        @(negedge clk);
        assert (spiCsN == 1'b1) else reportMismatch("spiCsN", 32'(spiCsN), 32'd1);
        assert (spiClk == 1'b0) else reportMismatch("spiClk", 32'(spiClk), 32'd0);
        assert (fetchBusy == 1'b0) else reportMismatch("fetchBusy", 32'(fetchBusy), 32'd0);
        assert (mapScrollPtr == 8'(scrollPkg::PtrStart))
            else reportMismatch("mapScrollPtr", 32'(mapScrollPtr), scrollPkg::PtrStart);
        assert (mapBackgroundCnt == 8'd0)
            else reportMismatch("mapBackgroundCnt", 32'(mapBackgroundCnt), 32'd0);
    endtask

    task automatic startRow(input stimRow_t row);
        @(posedge clk);
        scrollEn         <= 1'b0;   // restarts the controller at PtrStart
        scrollCntMax     <= row.cntMax;
        mapBackgroundMax <= row.bgMax;
        flashAddrStart   <= row.start;
        repeat (3) @(posedge clk);
        checkIdle();
        @(posedge clk);
        scrollEn <= 1'b1;
        modelPtr  = 9'(scrollPkg::PtrStart);
        modelPrev = 9'd0;
        modelCnt  = 8'd0;
        modelDiv  = 8'd0;
    endtask

    task automatic runFrame();
        logic stepped;
        logic nameDue;
        logic attrDue;
        stepped = 1'b0;
        if (modelCnt <= mapBackgroundMax) begin
            if (modelDiv == scrollCntMax) begin
                modelDiv  = 8'd0;
                stepped   = 1'b1;
                modelPrev = modelPtr;
                if (modelPtr == 9'd256) begin
                    modelPtr = 9'd239;
                    modelCnt = modelCnt + 8'd1;
                end else if (modelPtr == 9'd0) begin
                    modelPtr = 9'd495;
                    modelCnt = modelCnt + 8'd1;
                end else begin
                    modelPtr = modelPtr - 9'd1;
                end
            end else begin
                modelDiv = modelDiv + 8'd1;
            end
        end
        nameDue = stepped && modelPtr[2:0] == 3'b111;
        attrDue = stepped && (modelPtr[4:0] == 5'h1F || modelPtr == 9'd495
                              || modelPtr == 9'd239);
        @(posedge clk);
        vgaIntr <= 1'b1;
        @(posedge clk);
        vgaIntr <= 1'b0;
        if (nameDue || attrDue) begin
            waitForBusy(1'b1, 20);
            waitForBusy(1'b0, 2000);
            if (nameDue)
                checkRow(imageBase() + 24'(modelPtr[7:3]) * 24'd32,
                         {modelPtr[8:3], 3'd0}, scrollPkg::NameRowBytes);
            if (attrDue)
                checkRow(imageBase() + 24'(scrollPkg::AttrOffset) + 24'(modelPtr[7:5]) * 24'd8,
                         {modelPtr[8], 8'd0} + 9'(scrollPkg::AttrRamBase)
                         + 9'({modelPtr[7:5], 1'b0}),
                         scrollPkg::AttrRowBytes);
        end else begin
            repeat (6) @(posedge clk);   // step lands two edges after the pulse
        end
        @(negedge clk);
        assert (mapScrollPtr == modelPtr[7:0])
            else reportMismatch("mapScrollPtr", 32'(mapScrollPtr), 32'(modelPtr[7:0]));
        assert (scrollPtrOut == modelPrev)
            else reportMismatch("scrollPtrOut", 32'(scrollPtrOut), 32'(modelPrev));
        assert (mapBackgroundCnt == modelCnt)
            else reportMismatch("mapBackgroundCnt", 32'(mapBackgroundCnt), 32'(modelCnt));
        assert (scrollingFlag == (modelCnt <= mapBackgroundMax))
            else reportMismatch("scrollingFlag", 32'(scrollingFlag),
                                32'(modelCnt <= mapBackgroundMax));
    endtask

    initial begin
        int r;
        int f;
        rstN             <= 1'b0;
        scrollEn         <= 1'b0;
        scrollCntMax     <= 8'd0;
        flashAddrStart   <= 24'd0;
        mapBackgroundMax <= 8'd0;
        vgaIntr          <= 1'b0;
        ramReadAddr      <= 9'd0;
        // cntMax, bgMax, flash start, frames, final pointer, final count
        stimTable[0] = '{8'd0, 8'd1, 24'h000000, 16'd262, 8'd239, 8'd2};  // both wraps
        stimTable[1] = '{8'd2, 8'd0, 24'h012340, 16'd45, 8'd239, 8'd1};   // freeze at 495
        stimTable[2] = '{8'd1, 8'd5, 24'h0A0B0C, 16'd30, 8'd235, 8'd1};
        stimTable[3] = '{8'd3, 8'd1, 24'h000800, 16'd48, 8'd238, 8'd1};
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        checkIdle();
        for (r = 0; r < 4 && timeouts == 0; r++) begin
            startRow(stimTable[r]);
            for (f = 0; f < int'(stimTable[r].frames) && timeouts == 0; f++)
                runFrame();
            @(negedge clk);
            assert (mapScrollPtr == stimTable[r].expPtr)
                else reportMismatch("final mapScrollPtr", 32'(mapScrollPtr),
                                    32'(stimTable[r].expPtr));
            assert (mapBackgroundCnt == stimTable[r].expCnt)
                else reportMismatch("final mapBackgroundCnt", 32'(mapBackgroundCnt),
                                    32'(stimTable[r].expCnt));
        end
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* spiFlashModel.sv */
`timescale 1ns/100ps

module spiFlashModel (
    input  logic spiClk,
    input  logic spiCsN,
    input  logic spiMosi,
    output logic spiMiso
);

    logic [31:0] cmdAddr;   // opcode and address as shifted in
    int          bitCnt;    // rising edges since spiCsN fell

    // content rule of the whole flash
    function automatic logic [7:0] flashByte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
    endfunction

    function automatic logic dataBit(input logic [23:0] addr, input int idx);
        logic [7:0] b;
        b = flashByte(addr + 24'(idx / 8));
        b = b << (idx % 8);   // MSB first
        return b[7];
    endfunction

    always @(posedge spiClk or posedge spiCsN) begin
        if (spiCsN) begin
            bitCnt <= 0;
        end else begin
            if (bitCnt < 32)
                cmdAddr <= {cmdAddr[30:0], spiMosi};
            bitCnt <= bitCnt + 1;
        end
    end

    // mode 0 data bit goes out on the falling edge after the address
    always @(negedge spiClk or posedge spiCsN) begin
        if (spiCsN)
            spiMiso <= 1'b0;
        else if (bitCnt >= 32 && cmdAddr[31:24] != 8'h03)
            spiMiso <= 1'b1;   // unknown opcode floats the bus high
        else if (bitCnt >= 32)
            spiMiso <= dataBit(cmdAddr[23:0], bitCnt - 32);
    end

endmodule

/* scrollSubsystem.sv */
`timescale 1ns/100ps

module scrollSubsystem (
    input  logic        clk,
    input  logic        rstN,
    input  logic        scrollEn,
    input  logic [7:0]  scrollCntMax,
    input  logic [23:0] flashAddrStart,
    input  logic [7:0]  mapBackgroundMax,
    input  logic        vgaIntr,
    input  logic [8:0]  ramReadAddr,
    output logic [7:0]  mapBackgroundCnt,
    output logic [7:0]  mapScrollPtr,
    output logic [8:0]  scrollPtrOut,
    output logic        scrollingFlag,
    output logic        fetchBusy,
    output logic [31:0] ramReadData,
    output logic        spiClk,
    output logic        spiCsN,
    output logic        spiMosi,
    input  logic        spiMiso
);

    scrollPkg::fetchReq_t fetchReq;
    scrollPkg::ramWrite_t nameWrite;
    scrollPkg::ramWrite_t attrWrite;
    logic                 readStart;
    logic [23:0]          readAddr;
    logic [5:0]           readLen;
    logic                 rxValid;
    logic [7:0]           rxByte;
    logic                 readDone;

    scrollCtrl ctrl_i (
        .clk              (clk),
        .rstN             (rstN),
        .scrollEn         (scrollEn),
        .scrollCntMax     (scrollCntMax),
        .flashAddrStart   (flashAddrStart),
        .mapBackgroundMax (mapBackgroundMax),
        .vgaIntr          (vgaIntr),
        .mapBackgroundCnt (mapBackgroundCnt),
        .mapScrollPtr     (mapScrollPtr),
        .scrollPtrOut     (scrollPtrOut),
        .scrollingFlag    (scrollingFlag),
        .fetchReq         (fetchReq)
    );

    flashToNametable fetch_i (
        .clk       (clk),
        .rstN      (rstN),
        .fetchReq  (fetchReq),
        .readStart (readStart),
        .readAddr  (readAddr),
        .readLen   (readLen),
        .rxValid   (rxValid),
        .rxByte    (rxByte),
        .readDone  (readDone),
        .nameWrite (nameWrite),
        .attrWrite (attrWrite),
        .fetchBusy (fetchBusy)
    );

    spiFlashReader spi_i (
        .clk       (clk),
        .rstN      (rstN),
        .readStart (readStart),
        .readAddr  (readAddr),
        .readLen   (readLen),
        .rxValid   (rxValid),
        .rxByte    (rxByte),
        .readDone  (readDone),
        .spiClk    (spiClk),
        .spiCsN    (spiCsN),
        .spiMosi   (spiMosi),
        .spiMiso   (spiMiso)
    );

    nameTableRam ram_i (
        .clk       (clk),
        .nameWrite (nameWrite),
        .attrWrite (attrWrite),
        .readAddr  (ramReadAddr),
        .readData  (ramReadData)
    );

endmodule

/* nameTableRam.sv */
`timescale 1ns/100ps

module nameTableRam (
    input  logic                 clk,
    input  scrollPkg::ramWrite_t nameWrite,
    input  scrollPkg::ramWrite_t attrWrite,
    input  logic [8:0]           readAddr,
    output logic [31:0]          readData
);

    // words 0..239 and 256..495 name rows, the rest attributes
    logic [31:0] mem [2**scrollPkg::PtrWidth];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (nameWrite.en[lane])
                mem[nameWrite.addr][lane*8 +: 8] <= nameWrite.data[lane*8 +: 8];
            if (attrWrite.en[lane])
                mem[attrWrite.addr][lane*8 +: 8] <= attrWrite.data[lane*8 +: 8];
        end
        readData <= mem[readAddr];   // renderer sees data one clk later
    end

endmodule

/* spiFlashReader.sv */
`timescale 1ns/100ps

module spiFlashReader (
    input  logic        clk,
    input  logic        rstN,
    input  logic        readStart,
    input  logic [23:0] readAddr,
    input  logic [5:0]  readLen,
    output logic        rxValid,
    output logic [7:0]  rxByte,
    output logic        readDone,
    output logic        spiClk,
    output logic        spiCsN,
    output logic        spiMosi,
    input  logic        spiMiso
);

    scrollPkg::spiState_e state;
    logic [31:0]          txShift;   // opcode then address, MSB first
    logic [7:0]           rxShift;
    logic [4:0]           bitCnt;
    logic [5:0]           bytesLeft;
    logic                 byteDone;

    assign spiMosi  = txShift[31];
    assign byteDone = (state == scrollPkg::spiReadData) && spiClk && (bitCnt[2:0] == 3'd7);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= scrollPkg::spiIdle;
            spiClk   <= 1'b0;
            spiCsN   <= 1'b1;
            rxValid  <= 1'b0;
            readDone <= 1'b0;
            bitCnt   <= '0;
            txShift  <= '0;
        end else begin
            rxValid  <= byteDone;
            readDone <= 1'b0;
            case (state)
                scrollPkg::spiIdle: begin
                    if (readStart) begin
                        state   <= scrollPkg::spiSendCmd;
                        spiCsN  <= 1'b0;
                        bitCnt  <= '0;
                        txShift <= {scrollPkg::opRead, readAddr};
                    end
                end
                scrollPkg::spiSendCmd, scrollPkg::spiSendAddr, scrollPkg::spiReadData: begin
                    spiClk <= !spiClk;
                    if (spiClk) begin  // falling edge, next bit out
                        txShift <= txShift << 1;
                        bitCnt  <= bitCnt + 5'd1;
                        if (state == scrollPkg::spiSendCmd && bitCnt == 5'd7) begin
                            state  <= scrollPkg::spiSendAddr;
                            bitCnt <= '0;
                        end else if (state == scrollPkg::spiSendAddr && bitCnt == 5'd23) begin
                            state  <= scrollPkg::spiReadData;
                            bitCnt <= '0;
                        end else if (byteDone && bytesLeft == 6'd1) begin
                            state  <= scrollPkg::spiFinish;
                            spiCsN <= 1'b1;
                        end
                    end
                end
                scrollPkg::spiFinish: begin
                    readDone <= 1'b1;
                    state    <= scrollPkg::spiIdle;
                end
                default: state <= scrollPkg::spiIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == scrollPkg::spiIdle && readStart)
            bytesLeft <= readLen;
        else if (byteDone)
            bytesLeft <= bytesLeft - 6'd1;
        if (state == scrollPkg::spiReadData && !spiClk)
            rxShift <= {rxShift[6:0], spiMiso};  // sampled on rising spiClk
        if (byteDone)
            rxByte <= rxShift;
    end

    assert property (@(posedge clk) disable iff (!rstN)
                     readStart |-> state == scrollPkg::spiIdle);

endmodule

/* flashToNametable.sv */
`timescale 1ns/100ps

module flashToNametable (
    input  logic                 clk,
    input  logic                 rstN,
    input  scrollPkg::fetchReq_t fetchReq,
    output logic                 readStart,
    output logic [23:0]          readAddr,
    output logic [5:0]           readLen,
    input  logic                 rxValid,
    input  logic [7:0]           rxByte,
    input  logic                 readDone,
    output scrollPkg::ramWrite_t nameWrite,
    output scrollPkg::ramWrite_t attrWrite,
    output logic                 fetchBusy
);

    scrollPkg::fetchState_e state;
    scrollPkg::fetchReq_t   reqQ;
    logic [4:0]             byteCnt;   // byte index inside the current read
    logic                   newReq;
    scrollPkg::ptr_t        rowBase;
    scrollPkg::ramWrite_t   wr;

    assign newReq    = fetchReq.nameValid || fetchReq.attrValid;
    assign fetchBusy = (state != scrollPkg::fetchIdle);

    always_ff @(posedge clk) begin
        if (newReq && state == scrollPkg::fetchIdle)
            reqQ <= fetchReq;
    end

    // name row first, attribute row second, each only if asked for
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= scrollPkg::fetchIdle;
            readStart <= 1'b0;
        end else begin
            readStart <= 1'b0;
            case (state)
                scrollPkg::fetchIdle: begin
                    if (newReq) begin
                        state     <= fetchReq.nameValid ? scrollPkg::fetchReadName
                                                        : scrollPkg::fetchReadAttr;
                        readStart <= 1'b1;
                    end
                end
                scrollPkg::fetchReadName: begin
                    if (readDone) begin
                        if (reqQ.attrValid) begin
                            state     <= scrollPkg::fetchReadAttr;
                            readStart <= 1'b1;
                        end else begin
                            state <= scrollPkg::fetchIdle;
                        end
                    end
                end
                scrollPkg::fetchReadAttr: begin
                    if (readDone)
                        state <= scrollPkg::fetchIdle;
                end
                default: state <= scrollPkg::fetchIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || readStart)
            byteCnt <= '0;
        else if (rxValid)
            byteCnt <= byteCnt + 5'd1;
    end

    assign readAddr = (state == scrollPkg::fetchReadAttr) ? reqQ.attrFlashAddr
                                                          : reqQ.nameFlashAddr;
    assign readLen  = (state == scrollPkg::fetchReadAttr) ? 6'(scrollPkg::AttrRowBytes)
                                                          : 6'(scrollPkg::NameRowBytes);
    assign rowBase  = (state == scrollPkg::fetchReadAttr) ? reqQ.attrRamAddr
                                                          : reqQ.nameRamAddr;

    // lane from the low two bits of the byte count
    assign wr.en   = rxValid ? (4'b0001 << byteCnt[1:0]) : 4'b0000;
    assign wr.addr = rowBase + scrollPkg::ptr_t'(byteCnt[4:2]);
    assign wr.data = {4{rxByte}};

    always_comb begin
        nameWrite = wr;
        attrWrite = wr;
        if (state != scrollPkg::fetchReadName)
            nameWrite.en = 4'b0000;
        if (state != scrollPkg::fetchReadAttr)
            attrWrite.en = 4'b0000;
    end

    // a fetch ends well inside the frame between two controller steps
    assert property (@(posedge clk) disable iff (!rstN) fetchBusy |-> !newReq);

    // every received byte lands in exactly one write port
    assert property (@(posedge clk) disable iff (!rstN)
                     rxValid |-> $onehot({nameWrite.en, attrWrite.en}));

endmodule

/* scrollCtrl.sv */
`timescale 1ns/100ps

module scrollCtrl (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 scrollEn,
    input  logic [7:0]           scrollCntMax,
    input  logic [23:0]          flashAddrStart,
    input  logic [7:0]           mapBackgroundMax,
    input  logic                 vgaIntr,
    output logic [7:0]           mapBackgroundCnt,
    output logic [7:0]           mapScrollPtr,
    output logic [8:0]           scrollPtrOut,
    output logic                 scrollingFlag,
    output scrollPkg::fetchReq_t fetchReq
);

    logic                  vgaIntrQ0;
    logic                  vgaIntrQ1;
    logic                  vgaEdge;
    logic [7:0]            divCnt;
    logic                  step;
    logic                  stepQ;
    scrollPkg::ptr_t       scrollPtr;
    scrollPkg::ptr_t       prevPtr;
    scrollPkg::flashAddr_t imageBase;

    assign scrollingFlag = scrollEn && (mapBackgroundCnt <= mapBackgroundMax);

    // vgaIntr is already in the clk domain, two flops only for the edge
    always_ff @(posedge clk) begin
        if (!rstN || !scrollEn) begin
            vgaIntrQ0 <= 1'b0;
            vgaIntrQ1 <= 1'b0;
        end else begin
            vgaIntrQ0 <= vgaIntr;
            vgaIntrQ1 <= vgaIntrQ0;
        end
    end

    assign vgaEdge = vgaIntrQ0 && !vgaIntrQ1;
    assign step    = vgaEdge && scrollingFlag && (divCnt == scrollCntMax);

    // frame divider, one step every scrollCntMax+1 frames
    always_ff @(posedge clk) begin
        if (!rstN || !scrollEn) begin
            divCnt <= '0;
        end else if (vgaEdge && scrollingFlag) begin
            if (divCnt >= scrollCntMax)
                divCnt <= '0;
            else
                divCnt <= divCnt + 8'd1;
        end
    end

    // pointer walks down 239..0 then 495..256 and back
    always_ff @(posedge clk) begin
        if (!rstN || !scrollEn) begin
            scrollPtr        <= scrollPkg::ptr_t'(scrollPkg::PtrStart);
            prevPtr          <= '0;
            mapBackgroundCnt <= '0;
            stepQ            <= 1'b0;
        end else begin
            stepQ <= step;
            if (step) begin
                prevPtr <= scrollPtr;
                if (scrollPtr == 9'd256) begin
                    scrollPtr        <= 9'd239;
                    mapBackgroundCnt <= mapBackgroundCnt + 8'd1;
                end else if (scrollPtr == 9'd0) begin
                    scrollPtr        <= 9'd495;
                    mapBackgroundCnt <= mapBackgroundCnt + 8'd1;
                end else begin
                    scrollPtr <= scrollPtr - 9'd1;
                end
            end
        end
    end

    assign imageBase = flashAddrStart
                     + scrollPkg::flashAddr_t'(mapBackgroundCnt)
                     * scrollPkg::flashAddr_t'(scrollPkg::MapStride);

    // new tile row every 8 lines, new attribute row every 32 or at a half's bottom
    assign fetchReq.nameValid = stepQ && (scrollPtr[2:0] == 3'b111);
    assign fetchReq.attrValid = stepQ && (scrollPtr[4:0] == 5'b11111
                                          || scrollPtr == 9'd495
                                          || scrollPtr == 9'd239);

    assign fetchReq.nameFlashAddr = imageBase
                                  + scrollPkg::flashAddr_t'({scrollPtr[7:3], 5'd0});
    assign fetchReq.attrFlashAddr = imageBase
                                  + scrollPkg::flashAddr_t'(scrollPkg::AttrOffset)
                                  + scrollPkg::flashAddr_t'({scrollPtr[7:5], 3'd0});

    assign fetchReq.nameRamAddr = {scrollPtr[8:3], 3'd0};
    assign fetchReq.attrRamAddr = {scrollPtr[8], 8'd0}
                                + scrollPkg::ptr_t'(scrollPkg::AttrRamBase)
                                + scrollPkg::ptr_t'({scrollPtr[7:5], 1'b0});

    assign mapScrollPtr = scrollPtr[7:0];
    assign scrollPtrOut = prevPtr;

    // lines 240..255 of each half hold attributes, never a scroll position
    assert property (@(posedge clk) disable iff (!rstN) step |=> scrollPtr[7:4] != 4'hF);

endmodule

/* scrollPkg.sv */
package scrollPkg;

    localparam int PtrWidth       = 9;
    localparam int FlashAddrWidth = 24;
    localparam int NameRowBytes   = 32;
    localparam int AttrRowBytes   = 8;
    localparam int MapStride      = 1024;  // flash bytes per background image
    localparam int AttrOffset     = 960;   // attribute block follows 30 tile rows
    localparam int AttrRamBase    = 240;
    localparam int PtrStart       = 10;

    typedef logic [PtrWidth-1:0]       ptr_t;
    typedef logic [FlashAddrWidth-1:0] flashAddr_t;

    typedef struct packed {
        logic       nameValid;
        logic       attrValid;
        flashAddr_t nameFlashAddr;
        flashAddr_t attrFlashAddr;
        ptr_t       nameRamAddr;
        ptr_t       attrRamAddr;
    } fetchReq_t;

    typedef struct packed {
        logic [3:0]  en;    // one-hot byte lane
        ptr_t        addr;
        logic [31:0] data;
    } ramWrite_t;

    typedef enum logic [1:0] {
        fetchIdle,
        fetchReadName,
        fetchReadAttr
    } fetchState_e;

    typedef enum logic [2:0] {
        spiIdle,
        spiSendCmd,
        spiSendAddr,
        spiReadData,
        spiFinish
    } spiState_e;

    typedef enum logic [7:0] {
        opRead = 8'h03
    } flashOpcode_e;

endpackage
